//--- logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int XLEN       = 32;
    localparam int RAM_WORDS  = 256;
    localparam int RAM_AW     = $clog2(RAM_WORDS);
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 8;

    // loads first, stores in the upper three codes.
    typedef enum logic [2:0] {
        OP_LD_B  = 3'd0,
        OP_LD_H  = 3'd1,
        OP_LD_W  = 3'd2,
        OP_LD_BU = 3'd3,
        OP_LD_HU = 3'd4,
        OP_ST_B  = 3'd5,
        OP_ST_H  = 3'd6,
        OP_ST_W  = 3'd7
    } lsu_op_t;

    // operation entering the pipeline.
    typedef struct packed {
        lsu_op_t                 op;
        logic [XLEN-1:0]         base;
        logic [XLEN-1:0]         offset;
        logic [XLEN-1:0]         wdata;
        logic [REG_ADDR_W-1:0]   waddr;
        logic [TAG_W-1:0]        tag;
    } lsu_req_t;

    // first stage register, read by the second stage.
    typedef struct packed {
        lsu_op_t                 op;
        logic                    mem_load;
        logic                    mem_store;
        logic                    mem_access_valid;
        logic [XLEN-1:0]         mem_addr;
        logic                    wreg;
        logic [REG_ADDR_W-1:0]   waddr;
        logic [XLEN-1:0]         wdata;
        logic [TAG_W-1:0]        tag;
    } mem1_mem2_t;

    // word access to the data memory.
    typedef struct packed {
        logic [XLEN-1:0]         word_addr;
        logic                    we;
        logic [3:0]              be;
        logic [XLEN-1:0]         wdata;
    } mem_req_t;

    typedef struct packed {
        logic                    wreg;
        logic                    data_ready;
        logic [REG_ADDR_W-1:0]   waddr;
        logic [XLEN-1:0]         wdata;
    } data_fwd_t;

    typedef struct packed {
        logic                    wreg;
        logic [REG_ADDR_W-1:0]   waddr;
        logic [XLEN-1:0]         wdata;
        logic [TAG_W-1:0]        tag;
    } mem2_wb_t;

endpackage

`default_nettype wire

//--- logic/pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req_valid_i,
    input  logic flush_i,
    input  logic advance_ready_i,
    output logic ready_o,
    output logic s1_load_o,
    output logic advance_o,
    output logic clear_o,
    output logic s1_valid_o,
    output logic wb_valid_o
);
    logic s1_valid;
    logic wb_valid;

    assign advance_o  = advance_ready_i & ~flush_i;
    assign ready_o    = (~s1_valid | advance_o) & ~flush_i;
    assign s1_load_o  = req_valid_i & ready_o;

    // empty first stage pushes a bubble into the buffer.
    assign clear_o    = ~s1_valid;

    assign s1_valid_o = s1_valid;
    assign wb_valid_o = wb_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (flush_i) begin
            s1_valid <= 1'b0;
        end else if (s1_load_o) begin
            s1_valid <= 1'b1;
        end else if (advance_o) begin
            s1_valid <= 1'b0;
        end
    end

    // one strobe per operation leaving the second stage.
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (flush_i) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= advance_o & s1_valid;
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_issue.sv
`timescale 1ns/1ps
`default_nettype none

module mem_issue
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       s1_load_i,
    input  logic       flush_i,
    input  logic       s1_valid_i,
    input  lsu_req_t   req_i,
    output mem1_mem2_t mem1_o,
    output logic       mem_valid_o,
    output mem_req_t   mem_req_o
);
    mem1_mem2_t      s1_d;
    mem1_mem2_t      s1_q;
    logic [XLEN-1:0] addr;
    logic            req_is_store;
    logic            aligned;

    assign addr         = req_i.base + req_i.offset;
    assign req_is_store = req_i.op inside {OP_ST_B, OP_ST_H, OP_ST_W};

    always_comb begin
        case (req_i.op)
            OP_LD_B, OP_LD_BU, OP_ST_B: aligned = 1'b1;
            OP_LD_H, OP_LD_HU, OP_ST_H: aligned = ~addr[0];
            default:                    aligned = (addr[1:0] == 2'b00);
        endcase
    end

    always_comb begin
        s1_d.op               = req_i.op;
        s1_d.mem_load         = ~req_is_store;
        s1_d.mem_store        = req_is_store;
        s1_d.mem_access_valid = aligned;
        s1_d.mem_addr         = addr;
        // misaligned loads still write back.
        s1_d.wreg             = ~req_is_store;
        s1_d.waddr            = req_i.waddr;
        s1_d.wdata            = req_i.wdata;
        s1_d.tag              = req_i.tag;
    end

    always_ff @(posedge clk) begin
        if (rst | flush_i) begin
            s1_q.mem_load         <= 1'b0;
            s1_q.mem_store        <= 1'b0;
            s1_q.mem_access_valid <= 1'b0;
            s1_q.wreg             <= 1'b0;
        end else if (s1_load_i) begin
            s1_q <= s1_d;
        end
    end

    // byte lanes from size and low address bits.
    always_comb begin
        mem_req_o.word_addr = XLEN'(s1_q.mem_addr[RAM_AW+1:2]);
        mem_req_o.we        = s1_q.mem_store;
        case (s1_q.op)
            OP_LD_B, OP_LD_BU, OP_ST_B: begin
                mem_req_o.be    = 4'b0001 << s1_q.mem_addr[1:0];
                mem_req_o.wdata = {4{s1_q.wdata[7:0]}};
            end
            OP_LD_H, OP_LD_HU, OP_ST_H: begin
                mem_req_o.be    = s1_q.mem_addr[1] ? 4'b1100 : 4'b0011;
                mem_req_o.wdata = {2{s1_q.wdata[15:0]}};
            end
            default: begin
                mem_req_o.be    = 4'b1111;
                mem_req_o.wdata = s1_q.wdata;
            end
        endcase
    end

    assign mem_valid_o = s1_valid_i & s1_q.mem_access_valid;

    // empty stage is seen downstream as a bubble.
    assign mem1_o = s1_valid_i ? s1_q : '0;

endmodule

`default_nettype wire

//--- logic/mem_complete.sv
`timescale 1ns/1ps
`default_nettype none

module mem_complete
    import lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            clear_i,
    input  logic            advance_i,
    output logic            advance_ready_o,
    input  mem1_mem2_t      mem1_i,
    input  logic            data_ok_i,
    input  logic [XLEN-1:0] cache_data_i,
    output data_fwd_t       fwd_o,
    output mem2_wb_t        mem2_o_buffer
);
    mem2_wb_t        mem2_o;
    logic            data_already_ok;
    logic [XLEN-1:0] cache_data_delay;
    logic [XLEN-1:0] cache_data;
    logic            is_access;
    logic            is_valid_load;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;

    assign is_access     = (mem1_i.mem_load | mem1_i.mem_store) & mem1_i.mem_access_valid;
    assign is_valid_load = mem1_i.mem_load & mem1_i.mem_access_valid;

    // stores also hold the stage until the RAM answers.
    assign advance_ready_o = ~is_access | data_ok_i | data_already_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_already_ok <= 1'b0;
        end else if (advance_i | flush_i) begin
            data_already_ok <= 1'b0;
        end else if (data_ok_i) begin
            data_already_ok <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cache_data_delay <= '0;
        end else if (advance_i | flush_i) begin
            cache_data_delay <= '0;
        end else if (data_ok_i) begin
            cache_data_delay <= cache_data_i;
        end
    end

    assign cache_data = data_already_ok ? cache_data_delay : cache_data_i;

    always_comb begin
        case (mem1_i.mem_addr[1:0])
            2'b00:   ld_byte = cache_data[7:0];
            2'b01:   ld_byte = cache_data[15:8];
            2'b10:   ld_byte = cache_data[23:16];
            default: ld_byte = cache_data[31:24];
        endcase
        ld_half = mem1_i.mem_addr[1] ? cache_data[31:16] : cache_data[15:0];
    end

    always_comb begin
        mem2_o.wreg  = mem1_i.wreg;
        mem2_o.waddr = mem1_i.waddr;
        mem2_o.wdata = mem1_i.wdata;
        mem2_o.tag   = mem1_i.tag;
        if (mem1_i.mem_load) begin
            if (!mem1_i.mem_access_valid) begin
                mem2_o.wdata = '0;
            end else begin
                case (mem1_i.op)
                    OP_LD_B:  mem2_o.wdata = {{(XLEN-8){ld_byte[7]}}, ld_byte};
                    OP_LD_BU: mem2_o.wdata = {{(XLEN-8){1'b0}}, ld_byte};
                    OP_LD_H:  mem2_o.wdata = {{(XLEN-16){ld_half[15]}}, ld_half};
                    OP_LD_HU: mem2_o.wdata = {{(XLEN-16){1'b0}}, ld_half};
                    default:  mem2_o.wdata = cache_data;
                endcase
            end
        end
    end

    // forwarding is ready at once unless a load still waits.
    always_comb begin
        fwd_o.wreg       = mem2_o.wreg;
        fwd_o.data_ready = is_valid_load ? (data_ok_i | data_already_ok) : 1'b1;
        fwd_o.waddr      = mem2_o.waddr;
        fwd_o.wdata      = mem2_o.wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem2_o_buffer <= '0;
        end else if (flush_i | clear_i) begin
            mem2_o_buffer <= '0;
        end else if (advance_i) begin
            mem2_o_buffer <= mem2_o;
        end
    end

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            flush_i,
    input  logic            mem_valid_i,
    input  mem_req_t        mem_req_i,
    output logic            data_ok_o,
    output logic [XLEN-1:0] rdata_o
);
    logic [XLEN-1:0]   mem [RAM_WORDS];
    logic [RAM_AW-1:0] sweep_idx;
    logic              sweeping;
    logic              busy;
    logic [1:0]        delay_cnt;
    logic [15:0]       lfsr;
    logic              lfsr_fb;
    mem_req_t          req_q;
    logic [RAM_AW-1:0] idx;
    logic              start;

    assign idx     = req_q.word_addr[RAM_AW-1:0];
    assign start   = mem_valid_i & ~busy & ~sweeping & ~flush_i;
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    assign data_ok_o = busy & (delay_cnt == 2'd0);
    // old word, read before the store lands.
    assign rdata_o   = mem[idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
            busy      <= 1'b0;
            delay_cnt <= 2'd0;
            lfsr      <= 16'hace1;
        end else begin
            if (sweeping) begin
                sweep_idx <= sweep_idx + 1'b1;
                if (sweep_idx == RAM_AW'(RAM_WORDS - 1)) begin
                    sweeping <= 1'b0;
                end
            end
            if (flush_i) begin
                busy <= 1'b0;
            end else if (start) begin
                // 1 to 4 cycles until data_ok.
                busy      <= 1'b1;
                delay_cnt <= lfsr[1:0];
                lfsr      <= {lfsr[14:0], lfsr_fb};
            end else if (data_ok_o) begin
                busy <= 1'b0;
            end else if (busy) begin
                delay_cnt <= delay_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_q <= mem_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem[sweep_idx] <= '0;
        end else if (data_ok_o && req_q.we && !flush_i) begin
            for (int b = 0; b < 4; b++) begin
                if (req_q.be[b]) begin
                    mem[idx][8*b +: 8] <= req_q.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid_i,
    input  lsu_req_t  req_i,
    output logic      ready_o,
    input  logic      flush_i,
    output logic      wb_valid_o,
    output mem2_wb_t  wb_o,
    output data_fwd_t fwd_o
);
    logic            s1_load;
    logic            s1_valid;
    logic            advance;
    logic            advance_ready;
    logic            clear;
    mem1_mem2_t      mem1;
    logic            mem_valid;
    mem_req_t        mem_req;
    logic            data_ok;
    logic [XLEN-1:0] rdata;

    pipe_ctrl u_pipe_ctrl (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .flush_i         (flush_i),
        .advance_ready_i (advance_ready),
        .ready_o         (ready_o),
        .s1_load_o       (s1_load),
        .advance_o       (advance),
        .clear_o         (clear),
        .s1_valid_o      (s1_valid),
        .wb_valid_o      (wb_valid_o)
    );

    mem_issue u_mem_issue (
        .clk         (clk),
        .rst         (rst),
        .s1_load_i   (s1_load),
        .flush_i     (flush_i),
        .s1_valid_i  (s1_valid),
        .req_i       (req_i),
        .mem1_o      (mem1),
        .mem_valid_o (mem_valid),
        .mem_req_o   (mem_req)
    );

    mem_complete u_mem_complete (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .clear_i         (clear),
        .advance_i       (advance),
        .advance_ready_o (advance_ready),
        .mem1_i          (mem1),
        .data_ok_i       (data_ok),
        .cache_data_i    (rdata),
        .fwd_o           (fwd_o),
        .mem2_o_buffer   (wb_o)
    );

    data_ram u_data_ram (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .mem_valid_i (mem_valid),
        .mem_req_i   (mem_req),
        .data_ok_o   (data_ok),
        .rdata_o     (rdata)
    );

endmodule

`default_nettype wire

//--- tests/lsu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions
    import lsu_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       flush_i,
    input logic       clear_i,
    input logic       advance_i,
    input logic       advance_ready_i,
    input mem1_mem2_t mem1_i,
    input data_fwd_t  fwd_i,
    input mem2_wb_t   buffer_i
);
    int fail_count = 0;

    advance_gated: assert property (
        @(posedge clk) disable iff (rst) advance_i |-> advance_ready_i
    ) else begin
        $error("stage advanced while advance_ready was low");
        fail_count++;
    end

    // a load leaving the stage must have its data.
    load_fwd_ready: assert property (
        @(posedge clk) disable iff (rst)
        (advance_i && !clear_i && mem1_i.mem_load && mem1_i.mem_access_valid)
            |-> fwd_i.data_ready
    ) else begin
        $error("valid load loaded into the buffer without fwd data_ready");
        fail_count++;
    end

    flush_empties_buffer: assert property (
        @(posedge clk) disable iff (rst) flush_i |=> (buffer_i == '0)
    ) else begin
        $error("writeback buffer not empty in the cycle after flush");
        fail_count++;
    end

endmodule

bind mem_complete lsu_assertions u_assert (
    .clk             (clk),
    .rst             (rst),
    .flush_i         (flush_i),
    .clear_i         (clear_i),
    .advance_i       (advance_i),
    .advance_ready_i (advance_ready_o),
    .mem1_i          (mem1_i),
    .fwd_i           (fwd_o),
    .buffer_i        (mem2_o_buffer)
);

`default_nettype wire

//--- tests/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();
    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 8;
    localparam int N_OPS          = 158;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + RAM_WORDS + N_OPS * 6 + 200;

    typedef struct packed {
        mem2_wb_t wb;
        logic     chk_fwd;
    } exp_wb_t;

    logic             clk;
    logic             rst;
    logic             req_valid;
    lsu_req_t         req;
    logic             ready;
    logic             flush;
    logic             wb_valid;
    mem2_wb_t         wb;
    data_fwd_t        fwd;
    logic [XLEN-1:0]  ref_mem [RAM_WORDS];
    exp_wb_t          exp_q [$];
    logic             flushed_tag [256];
    logic [TAG_W-1:0] next_tag;
    integer           seed;
    int               cycle_count;
    int               errors;
    data_fwd_t        prev_fwd;
    string            test_name;

    lsu_top UUT (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .ready_o     (ready),
        .flush_i     (flush),
        .wb_valid_o  (wb_valid),
        .wb_o        (wb),
        .fwd_o       (fwd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        errors++;
        $display("ERROR: %s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic is_aligned(input lsu_op_t op, input logic [XLEN-1:0] addr);
        if (op inside {OP_LD_H, OP_LD_HU, OP_ST_H}) begin
            return ~addr[0];
        end
        if (op inside {OP_LD_W, OP_ST_W}) begin
            return addr[1:0] == 2'b00;
        end
        return 1'b1;
    endfunction

    // extended load value; misaligned loads give zero.
    function automatic logic [XLEN-1:0] expected_load(input lsu_op_t op,
            input logic [XLEN-1:0] addr, input logic [XLEN-1:0] word);
        logic [XLEN-1:0] lane;
        lane = word >> (8 * addr[1:0]);
        if (!is_aligned(op, addr)) begin
            return '0;
        end
        case (op)
            OP_LD_B:  return {{24{lane[7]}}, lane[7:0]};
            OP_LD_BU: return {24'h0, lane[7:0]};
            OP_LD_H:  return {{16{lane[15]}}, lane[15:0]};
            OP_LD_HU: return {16'h0, lane[15:0]};
            default:  return word;
        endcase
    endfunction

    task automatic send_op(input lsu_op_t op, input logic [XLEN-1:0] base,
                           input logic [XLEN-1:0] offset, input logic [XLEN-1:0] wdata,
                           input logic [REG_ADDR_W-1:0] waddr);
        logic [XLEN-1:0]   addr;
        logic [RAM_AW-1:0] idx;
        logic              is_store;
        exp_wb_t           e;
        addr     = base + offset;
        idx      = addr[RAM_AW+1:2];
        is_store = op inside {OP_ST_B, OP_ST_H, OP_ST_W};
        @(negedge clk);
        req_valid  = 1'b1;
        req.op     = op;
        req.base   = base;
        req.offset = offset;
        req.wdata  = wdata;
        req.waddr  = waddr;
        req.tag    = next_tag;
        while (!ready) @(negedge clk);
        // accepted at the coming rising edge.
        e.wb.wreg  = ~is_store;
        e.wb.waddr = waddr;
        e.wb.tag   = next_tag;
        e.wb.wdata = is_store ? wdata : expected_load(op, addr, ref_mem[idx]);
        e.chk_fwd  = ~is_store;
        exp_q.push_back(e);
        if (is_store && is_aligned(op, addr)) begin
            case (op)
                OP_ST_B: ref_mem[idx][8*addr[1:0] +: 8]  = wdata[7:0];
                OP_ST_H: ref_mem[idx][16*addr[1] +: 16]  = wdata[15:0];
                default: ref_mem[idx]                    = wdata;
            endcase
        end
        next_tag++;
        @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        @(negedge clk);
        req_valid = 1'b0;
        repeat (n - 1) @(negedge clk);
    endtask

    task automatic wait_drain();
        idle_cycles(1);
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic flush_pipeline();
        @(negedge clk);
        req_valid = 1'b0;
        flush     = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        // whatever is still queued was dropped.
        while (exp_q.size() != 0) begin
            flushed_tag[exp_q[0].wb.tag] = 1'b1;
            void'(exp_q.pop_front());
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("timeout, the pipeline stopped completing operations");
        end
    end

    always @(negedge clk) begin
        exp_wb_t e;
        if (!rst && wb_valid) begin
            if (flushed_tag[wb.tag]) begin
                stop_with_failure("a flushed operation wrote back");
            end else if (exp_q.size() == 0) begin
                stop_with_failure("writeback strobe with no operation outstanding");
            end else begin
                e = exp_q.pop_front();
                check_value("tag", e.wb.tag, wb.tag);
                check_value("waddr", e.wb.waddr, wb.waddr);
                check_value("wreg", e.wb.wreg, wb.wreg);
                check_value("wdata", e.wb.wdata, wb.wdata);
                if (e.chk_fwd) begin
                    check_value("fwd_ready_before_wb", 1, prev_fwd.data_ready);
                end
                // forwarding shows the record in the cycle it leaves the stage.
                check_value("fwd_wreg", e.wb.wreg, prev_fwd.wreg);
                check_value("fwd_waddr", e.wb.waddr, prev_fwd.waddr);
                check_value("fwd_wdata", e.wb.wdata, prev_fwd.wdata);
            end
        end
        prev_fwd = fwd;
    end

    initial begin
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        logic [2:0]      op_bits;
        int              gap;
        seed           = 32'he31e_2e95;
        rst            = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        flush          = 1'b0;
        next_tag       = '0;
        cycle_count    = 0;
        errors         = 0;
        prev_fwd       = '0;
        test_name      = "reset_state";
        foreach (ref_mem[i]) ref_mem[i] = '0;
        foreach (flushed_tag[i]) flushed_tag[i] = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // ram clears itself one word per cycle.
        repeat (RAM_WORDS + 4) @(negedge clk);
        check_value("ready", 1, ready);
        check_value("wb_valid", 0, wb_valid);
        check_value("fwd_data_ready", 1, fwd.data_ready);
        check_value("fwd_wreg", 0, fwd.wreg);

        test_name = "word_store_load";
        for (int i = 0; i < 16; i++) begin
            addr = ({$random(seed)} % RAM_WORDS) * 4;
            data = $random(seed);
            send_op(OP_ST_W, addr & 32'hffff_fff0, addr & 32'hc, data, 5'd1);
            send_op(OP_LD_W, addr, 32'd0, 32'd0, 5'(i + 1));
        end
        wait_drain();

        test_name = "byte_half_extend";
        for (int r = 0; r < 2; r++) begin
            for (int b = 0; b < 4; b++) begin
                data    = $random(seed);
                data[7] = r[0];
                send_op(OP_ST_B, 32'h100, b, data, 5'd2);
                send_op(OP_LD_B, 32'h100, b, 32'd0, 5'd3);
                send_op(OP_LD_BU, 32'h100, b, 32'd0, 5'd4);
            end
            for (int h = 0; h < 2; h++) begin
                data     = $random(seed);
                data[15] = r[0];
                send_op(OP_ST_H, 32'h104, 2 * h, data, 5'd2);
                send_op(OP_LD_H, 32'h104, 2 * h, 32'd0, 5'd5);
                send_op(OP_LD_HU, 32'h104, 2 * h, 32'd0, 5'd6);
            end
        end
        wait_drain();

        test_name = "misaligned";
        send_op(OP_ST_W, 32'h200, 32'd0, 32'h89ab_cdef, 5'd0);
        send_op(OP_LD_H, 32'h200, 32'd1, 32'd0, 5'd7);
        send_op(OP_LD_H, 32'h200, 32'd3, 32'd0, 5'd7);
        send_op(OP_LD_HU, 32'h200, 32'd1, 32'd0, 5'd8);
        for (int k = 1; k < 4; k++) begin
            send_op(OP_LD_W, 32'h200, k, 32'd0, 5'd9);
        end
        send_op(OP_ST_H, 32'h200, 32'd1, 32'h0000_5a5a, 5'd0);
        send_op(OP_ST_W, 32'h200, 32'd2, 32'h1234_5678, 5'd0);
        send_op(OP_LD_W, 32'h200, 32'd0, 32'd0, 5'd10);
        wait_drain();

        test_name = "random_stream";
        for (int i = 0; i < 64; i++) begin
            addr    = {$random(seed)} % (RAM_WORDS * 4);
            op_bits = $random(seed);
            data    = $random(seed);
            send_op(lsu_op_t'(op_bits), addr & 32'hffff_fffc, addr & 32'h3, data,
                    5'($random(seed)));
            gap = {$random(seed)} % 4;
            if (gap != 0) begin
                idle_cycles(gap);
            end
        end
        wait_drain();

        test_name = "flush_in_flight";
        for (int r = 0; r < 4; r++) begin
            send_op(OP_LD_W, 32'h300, 4 * r, 32'd0, 5'd11);
            send_op(OP_LD_B, 32'h300, 4 * r + 1, 32'd0, 5'd12);
            // odd rounds flush while the ram is busy.
            if (r % 2 == 1) begin
                idle_cycles(1);
            end
            flush_pipeline();
            data = $random(seed);
            send_op(OP_ST_W, 32'h380, 4 * r, data, 5'd0);
            send_op(OP_LD_W, 32'h380, 4 * r, 32'd0, 5'd13);
            wait_drain();
        end

        repeat (4) @(negedge clk);
        errors = errors + UUT.u_mem_complete.u_assert.fail_count;
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
logic/lsu_pkg.sv
logic/pipe_ctrl.sv
logic/mem_issue.sv
logic/mem_complete.sv
logic/data_ram.sv
logic/lsu_top.sv
tests/lsu_assertions.sv
tests/lsu_tb.sv
